// File: source/uart_pkg.sv
// ================================================
// Serial link package
// Byte type and 115200 baud timing for a 50 MHz clock
// ================================================
package uart_pkg;

  // One character on the serial line
  typedef logic [7:0] byte_t;

  // 50 MHz / 115200 baud, rounded
  localparam logic [8:0] CLKS_PER_BIT = 9'd434;

  // Data bits per character, no parity
  localparam int DATA_BITS = 8;

endpackage

// File: source/frame_pkg.sv
// ================================================
// Frame buffer package
// Image bank address map, image index and display types
// ================================================
package frame_pkg;

  // ================================================
  // Frame buffer addressing
  // ================================================
  typedef logic [22:0] addr_t;
  typedef logic [7:0]  img_idx_t;

  // Stored images start above the live raw frame
  localparam addr_t IMG_BASE   = 23'h100000;
  // One 640 by 480 image
  localparam addr_t IMG_STRIDE = 23'h04B000;
  localparam addr_t RAW_BASE   = 23'h000000;

  // Bytes sent per streamed frame
  localparam int FRAME_BYTES_DEFAULT = 307200;

  // ================================================
  // Status display
  // ================================================
  // Segments gfedcba, lit when low
  typedef logic [6:0] seg_t;

  localparam int NUM_DIGITS = 6;

endpackage

// File: source/byte_tx_if.sv
// ================================================
// Byte handshake between frame streamer and transmitter
// ================================================
interface byte_tx_if;
  import uart_pkg::*;

  byte_t data;
  // One-cycle request, only while busy is low
  logic  start;
  logic  busy;
  // Pulses as busy falls
  logic  done;

  modport source (output data, output start, input busy, input done);
  modport sink (input data, input start, output busy, output done);

endinterface

// File: source/uart_rx.sv
// ================================================
// Serial receiver, 8N1
// Samples mid-bit and flags each byte for one cycle
// ================================================
module uart_rx (
  input  logic            CLOCK_50,
  input  logic            DLY_RST_0,
  input  logic            rxd,
  output uart_pkg::byte_t rx_data,
  output logic            rx_valid
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t  state;
  logic       rxd_meta;
  logic       rxd_sync;
  logic [8:0] clk_cnt;
  logic [2:0] bit_cnt;
  logic       bit_done;
  byte_t      shreg;

  // Line is idle high
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  assign bit_done = (clk_cnt == CLKS_PER_BIT - 9'd1);

  // LSB arrives first
  always_ff @(posedge CLOCK_50) begin
    if (state == ST_DATA && bit_done) begin
      shreg <= {rxd_sync, shreg[DATA_BITS-1:1]};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= ST_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_data  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          if (!rxd_sync) begin
            state <= ST_START;
          end
        end
        // Recheck the start bit half a bit later, drop glitches
        ST_START: begin
          if (clk_cnt == (CLKS_PER_BIT >> 1) - 9'd1) begin
            clk_cnt <= '0;
            state   <= rxd_sync ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt <= clk_cnt + 9'd1;
          end
        end
        ST_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'(DATA_BITS - 1)) begin
              state <= ST_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 9'd1;
          end
        end
        // Middle of the stop bit; a low stop bit is a framing error
        ST_STOP: begin
          if (bit_done) begin
            state <= ST_IDLE;
            if (rxd_sync) begin
              rx_data  <= shreg;
              rx_valid <= 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 9'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: source/uart_tx.sv
// ================================================
// Serial transmitter, 8N1
// Start, busy and done handshake on the byte port
// ================================================
module uart_tx (
  input  logic     CLOCK_50,
  input  logic     DLY_RST_0,
  byte_tx_if.sink  tx,
  output logic     txd
);
  import uart_pkg::*;

  logic [DATA_BITS:0] shreg;
  logic [8:0]         clk_cnt;
  logic [3:0]         bit_idx;
  logic               bit_done;
  logic               load;

  assign load     = tx.start && !tx.busy;
  assign bit_done = tx.busy && (clk_cnt == CLKS_PER_BIT - 9'd1);

  // Data bits then stop bit, shifted out LSB first
  always_ff @(posedge CLOCK_50) begin
    if (load) begin
      shreg <= {1'b1, tx.data};
    end else if (bit_done) begin
      shreg <= {1'b1, shreg[DATA_BITS:1]};
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      txd     <= 1'b1;
      tx.busy <= 1'b0;
      tx.done <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
    end else begin
      tx.done <= 1'b0;
      if (load) begin
        // Start bit goes out right away
        txd     <= 1'b0;
        tx.busy <= 1'b1;
        clk_cnt <= '0;
        bit_idx <= '0;
      end else if (tx.busy) begin
        if (bit_done) begin
          clk_cnt <= '0;
          // Index 9 is the stop bit
          if (bit_idx == 4'(DATA_BITS + 1)) begin
            txd     <= 1'b1;
            tx.busy <= 1'b0;
            tx.done <= 1'b1;
          end else begin
            bit_idx <= bit_idx + 4'd1;
            txd     <= shreg[0];
          end
        end else begin
          clk_cnt <= clk_cnt + 9'd1;
        end
      end
    end
  end

endmodule

// File: source/image_select.sv
// ================================================
// Image select and frame store control
// Current image, read base address and display restart
// ================================================
module image_select (
  input  logic               CLOCK_50,
  input  logic               DLY_RST_0,
  input  uart_pkg::byte_t    rx_data,
  input  logic               rx_valid,
  input  logic               sw_store,
  input  logic               sw_raw,
  output frame_pkg::img_idx_t cur_img,
  output frame_pkg::addr_t   read_base,
  output uart_pkg::byte_t    store_data,
  output logic               store_we,
  output logic               disp_restart
);
  import frame_pkg::*;

  logic                     raw_meta;
  logic                     raw_sync;
  logic [$bits(img_idx_t):0] pair_now;
  logic [$bits(img_idx_t):0] pair_q;

  // Raw mode reads the live frame
  assign read_base = sw_raw ? RAW_BASE : IMG_BASE + IMG_STRIDE * addr_t'(cur_img);

  // Select mode loads the image, store mode forwards the byte
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_img  <= '0;
      store_we <= 1'b0;
    end else begin
      store_we <= rx_valid && sw_store;
      if (rx_valid && !sw_store) begin
        cur_img <= rx_data;
      end
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (rx_valid && sw_store) begin
      store_data <= rx_data;
    end
  end

  // ================================================
  // Display restart on any image or mode change
  // ================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      raw_meta <= 1'b0;
      raw_sync <= 1'b0;
    end else begin
      raw_meta <= sw_raw;
      raw_sync <= raw_meta;
    end
  end

  assign pair_now = {cur_img, raw_sync};

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      pair_q       <= '0;
      disp_restart <= 1'b1;
    end else begin
      pair_q       <= pair_now;
      disp_restart <= (pair_now == pair_q);
    end
  end

endmodule

// File: source/frame_streamer.sv
// ================================================
// Frame streamer
// Sends one frame of pixel bytes to the transmitter
// ================================================
module frame_streamer #(
  parameter int FRAME_BYTES = frame_pkg::FRAME_BYTES_DEFAULT
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  logic             key_start,
  input  logic             key_stop,
  input  uart_pkg::byte_t  pix_data,
  output logic             pix_req,
  byte_tx_if.source        tx,
  output logic             tx_active
);
  localparam int CNT_W = $clog2(FRAME_BYTES + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(FRAME_BYTES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_LOAD,
    ST_WAIT
  } st_t;

  st_t              state;
  logic             start_meta;
  logic             start_sync;
  logic             start_prev;
  logic             stop_meta;
  logic             stop_sync;
  logic             start_press;
  logic             last_byte;
  logic [CNT_W-1:0] byte_cnt;

  // Keys are active low, idle high
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      start_meta <= 1'b1;
      start_sync <= 1'b1;
      start_prev <= 1'b1;
      stop_meta  <= 1'b1;
      stop_sync  <= 1'b1;
    end else begin
      start_meta <= key_start;
      start_sync <= start_meta;
      start_prev <= start_sync;
      stop_meta  <= key_stop;
      stop_sync  <= stop_meta;
    end
  end

  assign start_press = !start_sync && start_prev;
  assign last_byte   = (byte_cnt == LAST_CNT);

  // Stop wins over start
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      tx_active <= 1'b0;
      byte_cnt  <= '0;
    end else if (!stop_sync) begin
      tx_active <= 1'b0;
    end else if (start_press) begin
      tx_active <= 1'b1;
      byte_cnt  <= '0;
    end else if (tx.done && tx_active) begin
      byte_cnt <= byte_cnt + 1'b1;
      if (last_byte) begin
        tx_active <= 1'b0;
      end
    end
  end

  // ================================================
  // Request, load, wait for done
  // ================================================
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (tx_active && !tx.busy) begin
            state <= ST_REQ;
          end
        end
        ST_REQ:  state <= ST_LOAD;
        ST_LOAD: state <= ST_WAIT;
        // An aborted character still runs to its stop bit
        ST_WAIT: begin
          if (tx.done) begin
            state <= (tx_active && !last_byte) ? ST_REQ : ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign pix_req  = (state == ST_REQ);
  // Pixel arrives the cycle after the request
  assign tx.start = (state == ST_LOAD);
  assign tx.data  = pix_data;

endmodule

// File: source/hex_display.sv
// ================================================
// Six-digit status display
// Image, last received byte and streaming flag
// ================================================
module hex_display (
  input  frame_pkg::img_idx_t cur_img,
  input  uart_pkg::byte_t     last_rx,
  input  logic                tx_active,
  output frame_pkg::seg_t     hex0,
  output frame_pkg::seg_t     hex1,
  output frame_pkg::seg_t     hex2,
  output frame_pkg::seg_t     hex3,
  output frame_pkg::seg_t     hex4,
  output frame_pkg::seg_t     hex5
);
  import frame_pkg::*;

  logic [4*NUM_DIGITS-1:0] value;
  seg_t                    segs [NUM_DIGITS];

  function automatic seg_t hex_to_seg(input logic [3:0] digit);
    case (digit)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // Top digit stays at zero
  assign value = {4'h0, 3'b000, tx_active, last_rx, cur_img};

  always_comb begin
    for (int i = 0; i < NUM_DIGITS; i++) begin
      segs[i] = hex_to_seg(value[4*i +: 4]);
    end
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];

endmodule

// File: source/image_bank_top.sv
// ================================================
// Image bank controller top level
// Serial command link, image select and frame streaming
// ================================================
module image_bank_top #(
  parameter int FRAME_BYTES = frame_pkg::FRAME_BYTES_DEFAULT
) (
  input  logic             CLOCK_50,
  input  logic             DLY_RST_0,
  input  logic             uart_rxd,
  input  logic             key_start,
  input  logic             key_stop,
  input  logic             sw_store,
  input  logic             sw_raw,
  input  uart_pkg::byte_t  pix_data,
  output logic             uart_txd,
  output logic             pix_req,
  output frame_pkg::addr_t read_base,
  output uart_pkg::byte_t  store_data,
  output logic             store_we,
  output logic             disp_restart,
  output frame_pkg::seg_t  hex0,
  output frame_pkg::seg_t  hex1,
  output frame_pkg::seg_t  hex2,
  output frame_pkg::seg_t  hex3,
  output frame_pkg::seg_t  hex4,
  output frame_pkg::seg_t  hex5
);

  uart_pkg::byte_t     rx_data;
  logic                rx_valid;
  frame_pkg::img_idx_t cur_img;
  logic                tx_active;

  byte_tx_if tx_bus ();

  // Command path
  uart_rx u_rx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (uart_rxd),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid)
  );

  image_select u_sel (
    .CLOCK_50     (CLOCK_50),
    .DLY_RST_0    (DLY_RST_0),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .sw_store     (sw_store),
    .sw_raw       (sw_raw),
    .cur_img      (cur_img),
    .read_base    (read_base),
    .store_data   (store_data),
    .store_we     (store_we),
    .disp_restart (disp_restart)
  );

  // Frame stream path
  frame_streamer #(
    .FRAME_BYTES (FRAME_BYTES)
  ) u_stream (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .key_start (key_start),
    .key_stop  (key_stop),
    .pix_data  (pix_data),
    .pix_req   (pix_req),
    .tx        (tx_bus.source),
    .tx_active (tx_active)
  );

  uart_tx u_tx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx        (tx_bus.sink),
    .txd       (uart_txd)
  );

  hex_display u_hex (
    .cur_img   (cur_img),
    .last_rx   (rx_data),
    .tx_active (tx_active),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

endmodule

// File: verif/tb_clock.sv
// ==================================================
// Testbench clock and reset
// 8 ns clock, reset held low for 8 cycles
// ==================================================
module tb_clock (
  output logic CLOCK_50,
  output logic DLY_RST_0
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLOCK_50 = 1'b0;
    forever #4 CLOCK_50 = ~CLOCK_50;
  end

  // Reset held for 8 rising edges
  initial begin
    DLY_RST_0 = 1'b0;
    repeat (8) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
  end

endmodule

// File: verif/tb_image_bank.sv
// ==================================================
// Image bank controller testbench
// Serial model, pixel source, reference model and checks
// ==================================================
module tb_image_bank;
  timeunit 1ns;
  timeprecision 100ps;
  import uart_pkg::*;
  import frame_pkg::*;

  localparam int FRAME_LEN  = 6;
  localparam int BIT_CYCLES = int'(CLKS_PER_BIT);

  typedef enum {MON_IDLE, MON_START, MON_DATA, MON_STOP} mon_state_t;

  logic       CLOCK_50;
  logic       DLY_RST_0;
  logic       uart_rxd  = 1'b1;
  logic       key_start = 1'b1;
  logic       key_stop  = 1'b1;
  logic       sw_store  = 1'b0;
  logic       sw_raw    = 1'b0;
  byte_t      pix_data  = 8'h00;
  logic       uart_txd;
  logic       pix_req;
  addr_t      read_base;
  byte_t      store_data;
  logic       store_we;
  logic       disp_restart;
  seg_t       hex0;
  seg_t       hex1;
  seg_t       hex2;
  seg_t       hex3;
  seg_t       hex4;
  seg_t       hex5;

  int         errors        = 0;
  int         seed          = 94732;
  int         req_seed      = 0;
  int         req_idx       = 0;
  logic       key_prev      = 1'b1;
  int         restart_count = 0;
  logic       restart_prev  = 1'b1;
  byte_t      store_q[$];
  byte_t      tx_q[$];
  logic       check_en      = 1'b0;
  byte_t      model_img     = 8'h00;
  logic       model_raw     = 1'b0;
  mon_state_t mon_state     = MON_IDLE;
  int         mon_cnt       = 0;
  int         mon_bits      = 0;
  byte_t      mon_shift     = 8'h00;

  tb_clock u_clk (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0)
  );

  image_bank_top #(
    .FRAME_BYTES (FRAME_LEN)
  ) dut (
    .CLOCK_50     (CLOCK_50),
    .DLY_RST_0    (DLY_RST_0),
    .uart_rxd     (uart_rxd),
    .key_start    (key_start),
    .key_stop     (key_stop),
    .sw_store     (sw_store),
    .sw_raw       (sw_raw),
    .pix_data     (pix_data),
    .uart_txd     (uart_txd),
    .pix_req      (pix_req),
    .read_base    (read_base),
    .store_data   (store_data),
    .store_we     (store_we),
    .disp_restart (disp_restart),
    .hex0         (hex0),
    .hex1         (hex1),
    .hex2         (hex2),
    .hex3         (hex3),
    .hex4         (hex4),
    .hex5         (hex5)
  );

  // ==================================================
  // Reference model
  // ==================================================
  // Pixel byte folded from all four bytes of the request index
  function automatic byte_t pattern_byte(input int unsigned idx);
    logic [31:0] k;
    k = idx;
    return (k[7:0] * 8'd29) ^ k[15:8] ^ k[23:16] ^ k[31:24] ^ 8'h5A;
  endfunction

  function automatic byte_t expected_char(input int k);
    return pattern_byte(req_seed + k);
  endfunction

  function automatic addr_t exp_read_base(input byte_t img, input logic raw);
    logic [31:0] full;
    full = 32'(IMG_BASE) + 32'(IMG_STRIDE) * 32'(img);
    if (raw) begin
      return RAW_BASE;
    end
    return full[22:0];
  endfunction

  // Segments gfedcba written lit high and then inverted
  function automatic seg_t seg_code(input logic [3:0] d);
    case (d)
      4'h0:    return ~7'b0111111;
      4'h1:    return ~7'b0000110;
      4'h2:    return ~7'b1011011;
      4'h3:    return ~7'b1001111;
      4'h4:    return ~7'b1100110;
      4'h5:    return ~7'b1101101;
      4'h6:    return ~7'b1111101;
      4'h7:    return ~7'b0000111;
      4'h8:    return ~7'b1111111;
      4'h9:    return ~7'b1101111;
      4'hA:    return ~7'b1110111;
      4'hB:    return ~7'b1111100;
      4'hC:    return ~7'b0111001;
      4'hD:    return ~7'b1011110;
      4'hE:    return ~7'b1111001;
      default: return ~7'b1110001;
    endcase
  endfunction

  // Entries captured so far by the store monitor or the serial decoder
  function automatic int captured_count(input bit from_tx);
    return from_tx ? tx_q.size() : store_q.size();
  endfunction

  // ==================================================
  // Reporting
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Run ended with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timed out at %0t ns waiting for %s", $time, what);
    finish_run();
  endtask

  // ==================================================
  // Monitors and pixel source
  // ==================================================
  always @(posedge CLOCK_50) begin
    key_prev <= key_start;
    if (!key_start && key_prev) begin
      req_idx <= 0;
    end else if (pix_req) begin
      pix_data <= pattern_byte(req_seed + req_idx);
      req_idx  <= req_idx + 1;
    end
  end

  // Restart pulses and store writes
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0) begin
      if (!disp_restart) begin
        restart_count++;
        assert (restart_prev) else begin
          errors++;
          $display("disp_restart stayed low for more than one cycle at %0t ns", $time);
        end
      end
      restart_prev = disp_restart;
      if (store_we) begin
        store_q.push_back(store_data);
      end
    end
  end

  // Serial decoder for uart_txd that samples mid-bit
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0) begin
      case (mon_state)
        MON_IDLE: begin
          if (!uart_txd) begin
            mon_cnt   = 1;
            mon_state = MON_START;
          end
        end
        MON_START: begin
          mon_cnt++;
          if (mon_cnt == BIT_CYCLES / 2) begin
            mon_cnt   = 0;
            mon_bits  = 0;
            mon_state = uart_txd ? MON_IDLE : MON_DATA;
          end
        end
        MON_DATA: begin
          mon_cnt++;
          if (mon_cnt == BIT_CYCLES) begin
            mon_cnt   = 0;
            mon_shift = {uart_txd, mon_shift[7:1]};
            mon_bits++;
            if (mon_bits == DATA_BITS) begin
              mon_state = MON_STOP;
            end
          end
        end
        default: begin
          mon_cnt++;
          if (mon_cnt == BIT_CYCLES) begin
            mon_state = MON_IDLE;
            assert (uart_txd) tx_q.push_back(mon_shift);
            else begin
              errors++;
              $display("Stop bit missing on uart_txd at %0t ns", $time);
            end
          end
        end
      endcase
    end
  end

  // Compare against the model while it is settled
  always @(negedge CLOCK_50) begin
    if (check_en) begin
      check_value("read_base", read_base, exp_read_base(model_img, model_raw));
      check_value("hex0", hex0, seg_code(model_img[3:0]));
      check_value("hex1", hex1, seg_code(model_img[7:4]));
      check_value("hex5", hex5, seg_code(4'h0));
    end
  end

  // ==================================================
  // Stimulus and waits
  // ==================================================
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge CLOCK_50);
      uart_rxd <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge CLOCK_50);
    end
  endtask

  task automatic wait_rx_shown(input byte_t b);
    int n;
    n = 0;
    while (!(hex2 === seg_code(b[3:0]) && hex3 === seg_code(b[7:4])) &&
           n < 2 * BIT_CYCLES) begin
      @(negedge CLOCK_50);
      n++;
    end
    assert (hex2 === seg_code(b[3:0]) && hex3 === seg_code(b[7:4]))
    else timed_out("hex2 and hex3 to show the received byte");
  endtask

  // Wait for the expected pulse count and then a quiet window
  task automatic wait_restarts(input int want);
    int n;
    n = 0;
    while (restart_count < want && n < 100) begin
      @(negedge CLOCK_50);
      n++;
    end
    assert (restart_count >= want) else timed_out("a disp_restart pulse");
    repeat (8) @(negedge CLOCK_50);
    check_value("disp_restart pulses", restart_count, want);
  endtask

  task automatic wait_count(input string what, input bit from_tx, input int want,
                            input int limit);
    int n;
    n = 0;
    while (captured_count(from_tx) < want && n < limit) begin
      @(negedge CLOCK_50);
      n++;
    end
    assert (captured_count(from_tx) >= want) else timed_out(what);
  endtask

  task automatic wait_hex4(input logic [3:0] d, input int limit, input string what);
    int n;
    n = 0;
    while (hex4 !== seg_code(d) && n < limit) begin
      @(negedge CLOCK_50);
      n++;
    end
    assert (hex4 === seg_code(d)) else timed_out(what);
  endtask

  task automatic select_image(input byte_t b);
    int want;
    @(negedge CLOCK_50);
    want = restart_count + ((b != model_img) ? 1 : 0);
    @(posedge CLOCK_50);
    check_en = 1'b0;
    send_byte(b);
    wait_rx_shown(b);
    wait_restarts(want);
    @(posedge CLOCK_50);
    model_img = b;
    check_en  = 1'b1;
  endtask

  task automatic set_raw(input logic value);
    int want;
    @(negedge CLOCK_50);
    want = restart_count + ((value != model_raw) ? 1 : 0);
    @(posedge CLOCK_50);
    sw_raw <= value;
    model_raw = value;
    wait_restarts(want);
  endtask

  // Image stays unchanged so the compare process keeps running
  task automatic store_byte(input byte_t b);
    int want;
    int n;
    @(negedge CLOCK_50);
    want = restart_count;
    n    = store_q.size();
    send_byte(b);
    wait_count("a store_we pulse", 1'b0, n + 1, 2 * BIT_CYCLES);
    wait_rx_shown(b);
    wait_restarts(want);
    check_value("store_we pulses", store_q.size(), n + 1);
    check_value("store_data", store_q[n], b);
  endtask

  task automatic press_key(input bit stop);
    @(posedge CLOCK_50);
    if (stop) begin
      key_stop <= 1'b0;
    end else begin
      key_start <= 1'b0;
    end
    repeat (10) @(posedge CLOCK_50);
    key_start <= 1'b1;
    key_stop  <= 1'b1;
  endtask

  task automatic check_stream_prefix();
    for (int k = 0; k < tx_q.size(); k++) begin
      check_value($sformatf("uart_txd char %0d", k), tx_q[k], expected_char(k));
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    req_seed = $random(seed);
    for (int n = 0; n < 50 && DLY_RST_0 !== 1'b1; n++) begin
      @(negedge CLOCK_50);
    end
    assert (DLY_RST_0 === 1'b1) else timed_out("reset release");
    @(negedge CLOCK_50);
    check_value("disp_restart", disp_restart, 1'b1);
    check_value("uart_txd", uart_txd, 1'b1);
    check_value("store_we", store_we, 1'b0);
    check_value("pix_req", pix_req, 1'b0);
    check_value("hex4", hex4, seg_code(4'h0));
    @(posedge CLOCK_50);
    check_en = 1'b1;

    // Select mode where the repeated byte gives no restart
    select_image(8'h03);
    select_image(8'h2A);
    select_image(8'h2A);
    select_image(8'hA7);

    // Raw mode on and off
    set_raw(1'b1);
    set_raw(1'b0);

    // Store mode
    @(posedge CLOCK_50);
    sw_store <= 1'b1;
    store_byte(8'h5C);
    store_byte(8'hE1);
    @(posedge CLOCK_50);
    sw_store <= 1'b0;

    // Full frame
    @(negedge CLOCK_50);
    tx_q.delete();
    press_key(1'b0);
    wait_hex4(4'h1, 20, "the streaming flag to rise");
    wait_hex4(4'h0, FRAME_LEN * 12 * BIT_CYCLES, "the frame stream to end");
    repeat (12 * BIT_CYCLES) @(negedge CLOCK_50);
    check_value("uart_txd char count", tx_q.size(), FRAME_LEN);
    check_stream_prefix();

    // Abort after two characters
    tx_q.delete();
    press_key(1'b0);
    wait_hex4(4'h1, 20, "the streaming flag to rise");
    wait_count("two streamed characters", 1'b1, 2, 3 * 12 * BIT_CYCLES);
    press_key(1'b1);
    wait_hex4(4'h0, 50, "the streaming flag to clear after key_stop");
    repeat (12 * BIT_CYCLES) @(negedge CLOCK_50);
    assert (tx_q.size() >= 2 && tx_q.size() < FRAME_LEN) else begin
      errors++;
      $display("Abort did not shorten the stream, %0d characters arrived", tx_q.size());
    end
    check_stream_prefix();

    finish_run();
  end

endmodule

// File: tb.f
source/uart_pkg.sv
source/frame_pkg.sv
source/byte_tx_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/image_select.sv
source/frame_streamer.sv
source/hex_display.sv
source/image_bank_top.sv
verif/tb_clock.sv
verif/tb_image_bank.sv

// File: Makefile
# Verilator build and run for the image bank testbench

TOP := tb_image_bank

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(wildcard source/*.sv verif/*.sv)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
